// ==== files.f ====
src/mapper_pkg.sv
src/mapper_regs.sv
src/region_decode.sv
src/dtack_gen.sv
src/mcu_bus_master.sv
src/sys_mapper.sv
tb/tb_clock.sv
tb/mapper_assertions.sv
tb/mapper_tb.sv

// ==== src/dtack_gen.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// dtack after delay+1 edges, no external dtack pin
// delay is taken from the decoder when the strobe first falls
// ------------------------------------------------------------
module dtack_gen
    import mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        asn,
    input  delay_code_t delay,
    output logic        cpu_dtackn
);

    logic        strobe_seen;   // asn has been sampled low this cycle
    delay_code_t dly;
    delay_code_t cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_seen <= 1'b0;
            cnt         <= '0;
            cpu_dtackn  <= 1'b1;
        end else if (asn) begin
            strobe_seen <= 1'b0;
            cnt         <= '0;
            cpu_dtackn  <= 1'b1;
        end else if (!strobe_seen) begin
            strobe_seen <= 1'b1;
        end else if (cnt == dly) begin
            cpu_dtackn <= 1'b0;         // stays low until asn rises
        end else begin
            cnt <= cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!asn && !strobe_seen)
            dly <= delay;
    end

endmodule

// ==== src/mapper_pkg.sv ====
// ------------------------------------------------------------
// shared types for the 68000 memory mapper
// addresses are word addresses, bit 0 of addr_t is cpu A1
// ------------------------------------------------------------
package mapper_pkg;

    localparam int NUM_REGIONS = 8;

    typedef logic [22:0] addr_t;        // A23..A1
    typedef logic [15:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  region_t;      // one-hot
    typedef logic [1:0]  delay_code_t;  // 0..3 -> 1..4 cycles
    typedef logic [1:0]  size_code_t;   // 64K, 128K, 512K, 2M

    typedef struct packed {
        logic       asn;
        logic       rnw;
        logic [1:0] dsn;
        logic [2:0] fc;
        addr_t      addr;
        data_t      dout;
    } cpu_bus_t;

    typedef struct packed {
        logic  rnw;
        addr_t addr;
        data_t wdata;
    } mem_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } xfer_state_e;

    // register map
    localparam reg_idx_t REG_DATA_HI     = 5'd0;
    localparam reg_idx_t REG_DATA_LO     = 5'd1;
    localparam reg_idx_t REG_SND         = 5'd3;
    localparam reg_idx_t REG_CMD         = 5'd5;
    localparam reg_idx_t REG_RDADDR      = 5'd7;   // 7..9, msb first
    localparam reg_idx_t REG_WRADDR      = 5'd10;  // 10..12, msb first
    localparam reg_idx_t REG_REGION_BASE = 5'd16;  // ctrl at 16+2r, base at 17+2r

    // REG_CMD bits 1:0
    localparam logic [1:0] CMD_WRITE = 2'b01;
    localparam logic [1:0] CMD_READ  = 2'b10;

    // addresses with special meaning on the mcu read side
    localparam reg_idx_t MCU_RD_STATUS = 5'd2;
    localparam reg_idx_t MCU_RD_SND    = 5'd3;

endpackage

// ==== src/mapper_regs.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// 32 byte register bank, cpu writes only land in unmapped space
// the first mcu write locks the cpu out until reset
// mcu port is assumed synchronous to clk
// ------------------------------------------------------------
module mapper_regs
    import mapper_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_bus_t                cpu,
    input  logic                    none,
    input  logic                    mcu_en,
    input  logic                    mcu_wr,
    input  reg_idx_t                mcu_addr,
    input  byte_t                   mcu_wdata,
    input  logic                    snd_wr,
    input  logic                    snd_rd,
    input  byte_t                   snd_din,
    input  logic                    busy,
    input  logic                    xfer_done,
    input  data_t                   xfer_rdata,
    output byte_t [NUM_REGIONS-1:0] region_base,
    output byte_t [NUM_REGIONS-1:0] region_ctrl,
    output logic                    xfer_start,
    output mem_cmd_t                xfer_cmd,
    output data_t                   mapper_dout,
    output byte_t                   mcu_rdata,
    output logic                    mcu_snd_intn,
    output byte_t                   snd_dout,
    output logic                    snd_pbf
);

    byte_t    mmr [32];
    logic     cpu_sel;                 // cpu may still write the bank
    logic     wren_cpu;
    logic     wren_cpu_l;
    logic     wren_mcu;
    logic     mcu_rd;
    logic     wr_en;
    reg_idx_t wr_idx;
    byte_t    wr_data;
    logic     cmd_ok;
    byte_t    snd_latch;
    byte_t    status;
    addr_t    rd_addr;
    addr_t    wr_addr;

    assign wren_cpu = ~cpu.asn & ~cpu.dsn[0] & ~cpu.rnw & none;
    assign wren_mcu = mcu_en & mcu_wr;
    assign mcu_rd   = mcu_en & ~mcu_wr;

    // mcu wins when both write in the same cycle
    assign wr_en   = wren_mcu | (wren_cpu & ~wren_cpu_l & cpu_sel);
    assign wr_idx  = wren_mcu ? mcu_addr : cpu.addr[4:0];
    assign wr_data = wren_mcu ? mcu_wdata : cpu.dout[7:0];

    assign rd_addr = {mmr[REG_RDADDR][6:0], mmr[REG_RDADDR+1], mmr[REG_RDADDR+2]};
    assign wr_addr = {mmr[REG_WRADDR][6:0], mmr[REG_WRADDR+1], mmr[REG_WRADDR+2]};

    // a second command is ignored until the running one finishes
    assign cmd_ok = wr_en && wr_idx == REG_CMD && !busy && !xfer_start &&
                    (wr_data[1:0] == CMD_WRITE || wr_data[1:0] == CMD_READ);

    assign mapper_dout = {mmr[REG_DATA_HI], mmr[REG_DATA_LO]};
    assign snd_dout    = mmr[REG_SND];

    genvar r;
    generate
        for (r = 0; r < NUM_REGIONS; r++) begin : g_region
            assign region_ctrl[r] = mmr[REG_REGION_BASE + 2*r];
            assign region_base[r] = mmr[REG_REGION_BASE + 2*r + 1];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                mmr[i] <= '0;
            cpu_sel    <= 1'b1;
            wren_cpu_l <= 1'b0;
            snd_pbf    <= 1'b0;
            xfer_start <= 1'b0;
        end else begin
            wren_cpu_l <= wren_cpu;    // one write per strobe
            xfer_start <= cmd_ok;
            if (wren_mcu)
                cpu_sel <= 1'b0;
            if (wr_en) begin
                mmr[wr_idx] <= wr_data;
                if (wr_idx == REG_SND)
                    snd_pbf <= 1'b1;
            end
            if (snd_rd)
                snd_pbf <= 1'b0;       // sound cpu took the byte
            if (xfer_done && xfer_cmd.rnw) begin
                mmr[REG_DATA_HI] <= xfer_rdata[15:8];
                mmr[REG_DATA_LO] <= xfer_rdata[7:0];
            end
        end
    end

    // command snapshot, held until the next start
    always_ff @(posedge clk) begin
        if (cmd_ok) begin
            xfer_cmd.rnw   <= wr_data[1];
            xfer_cmd.addr  <= wr_data[1] ? rd_addr : wr_addr;
            xfer_cmd.wdata <= {mmr[REG_DATA_HI], mmr[REG_DATA_LO]};
        end
    end

    // sound cpu to mcu direction
    always_ff @(posedge clk) begin
        if (rst) begin
            snd_latch    <= '0;
            mcu_snd_intn <= 1'b1;
        end else begin
            if (snd_wr) begin
                snd_latch    <= snd_din;
                mcu_snd_intn <= 1'b0;
            end
            if (mcu_rd && mcu_addr == MCU_RD_SND)
                mcu_snd_intn <= 1'b1;  // reading the latch acks the irq
        end
    end

    // bit 7 mcu owns the bank, 6 transfer busy, 5 buffer full, 0 sound irq pending
    assign status = {~cpu_sel, busy, snd_pbf, 4'b0000, ~mcu_snd_intn};

    always_ff @(posedge clk) begin
        if (mcu_rd) begin
            case (mcu_addr)
                MCU_RD_STATUS: mcu_rdata <= status;
                MCU_RD_SND:    mcu_rdata <= snd_latch;
                default:       mcu_rdata <= mmr[mcu_addr];
            endcase
        end
    end

endmodule

// ==== src/mcu_bus_master.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// one word per command over a four-phase req/ack port
// no timeout, a silent responder stalls the master
// ------------------------------------------------------------
module mcu_bus_master
    import mapper_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     xfer_start,
    input  mem_cmd_t xfer_cmd,
    input  logic     mem_ack,
    input  data_t    mem_rdata,
    output logic     mem_req,
    output mem_cmd_t mem_cmd,
    output logic     busy,
    output logic     xfer_done,
    output data_t    xfer_rdata,
    output logic     cpu_brn
);

    xfer_state_e state;

    // busy covers the done cycle so read data is stored before it drops
    assign busy    = (state != IDLE) | xfer_done;
    assign cpu_brn = ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            mem_req   <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (xfer_start) begin
                        mem_req <= 1'b1;
                        state   <= REQ;
                    end
                end
                REQ: begin
                    if (mem_ack) begin  // phase 3, drop the request
                        mem_req <= 1'b0;
                        state   <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!mem_ack) begin
                        state     <= IDLE;
                        xfer_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // command and read data registers
    always_ff @(posedge clk) begin
        if (state == IDLE && xfer_start)
            mem_cmd <= xfer_cmd;        // stable for the whole request
        if (state == REQ && mem_ack)
            xfer_rdata <= mem_rdata;
    end

endmodule

// ==== src/region_decode.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// purely combinational, region 0 has the highest priority
// fc all ones (interrupt ack) blanks every output
// ------------------------------------------------------------
module region_decode
    import mapper_pkg::*;
(
    input  addr_t                   addr,
    input  logic [2:0]              fc,
    input  byte_t [NUM_REGIONS-1:0] region_base,
    input  byte_t [NUM_REGIONS-1:0] region_ctrl,
    output region_t                 active,
    output logic                    none,
    output delay_code_t             delay
);

    // compare only the top bits that the region size leaves fixed
    function automatic logic hit(addr_t a, byte_t base, size_code_t size);
        case (size)
            2'd0:    hit = a[22:15] == base;       // 64 KB
            2'd1:    hit = a[22:16] == base[7:1];  // 128 KB
            2'd2:    hit = a[22:18] == base[7:3];  // 512 KB
            default: hit = a[22:20] == base[7:5];  // 2 MB
        endcase
    endfunction

    always_comb begin
        logic found;

        active = '0;
        delay  = '0;
        found  = 1'b0;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            if (!found && hit(addr, region_base[r], region_ctrl[r][1:0])) begin
                active[r] = 1'b1;
                delay     = region_ctrl[r][3:2];
                found     = 1'b1;
            end
        end
        none = ~found;

        if (&fc) begin
            active = '0;
            none   = 1'b0;
            delay  = '0;
        end
    end

endmodule

// ==== src/sys_mapper.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// memory mapper top, all blocks run on every clk edge
// the mcu and sound ports must be synchronous to clk
// ------------------------------------------------------------
module sys_mapper
    import mapper_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // 68000 side
    input  cpu_bus_t cpu,
    output logic     cpu_dtackn,
    output logic     cpu_brn,
    output data_t    mapper_dout,
    output region_t  active,
    output logic     none,
    // mcu side
    input  logic     mcu_en,
    input  logic     mcu_wr,
    input  reg_idx_t mcu_addr,
    input  byte_t    mcu_wdata,
    output byte_t    mcu_rdata,
    output logic     mcu_snd_intn,
    // sound cpu side
    input  logic     snd_wr,
    input  logic     snd_rd,
    input  byte_t    snd_din,
    output byte_t    snd_dout,
    output logic     snd_pbf,
    // memory port
    output logic     mem_req,
    output mem_cmd_t mem_cmd,
    input  logic     mem_ack,
    input  data_t    mem_rdata
);

    byte_t [NUM_REGIONS-1:0] region_base;
    byte_t [NUM_REGIONS-1:0] region_ctrl;
    logic                    xfer_start;
    mem_cmd_t                xfer_cmd;
    logic                    busy;
    logic                    xfer_done;
    data_t                   xfer_rdata;
    delay_code_t             delay;

    mapper_regs i_regs (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .none         (none),
        .mcu_en       (mcu_en),
        .mcu_wr       (mcu_wr),
        .mcu_addr     (mcu_addr),
        .mcu_wdata    (mcu_wdata),
        .snd_wr       (snd_wr),
        .snd_rd       (snd_rd),
        .snd_din      (snd_din),
        .busy         (busy),
        .xfer_done    (xfer_done),
        .xfer_rdata   (xfer_rdata),
        .region_base  (region_base),
        .region_ctrl  (region_ctrl),
        .xfer_start   (xfer_start),
        .xfer_cmd     (xfer_cmd),
        .mapper_dout  (mapper_dout),
        .mcu_rdata    (mcu_rdata),
        .mcu_snd_intn (mcu_snd_intn),
        .snd_dout     (snd_dout),
        .snd_pbf      (snd_pbf)
    );

    region_decode i_decode (
        .addr        (cpu.addr),
        .fc          (cpu.fc),
        .region_base (region_base),
        .region_ctrl (region_ctrl),
        .active      (active),
        .none        (none),
        .delay       (delay)
    );

    dtack_gen i_dtack (
        .clk        (clk),
        .rst        (rst),
        .asn        (cpu.asn),
        .delay      (delay),
        .cpu_dtackn (cpu_dtackn)
    );

    mcu_bus_master i_master (
        .clk        (clk),
        .rst        (rst),
        .xfer_start (xfer_start),
        .xfer_cmd   (xfer_cmd),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .busy       (busy),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata),
        .cpu_brn    (cpu_brn)
    );

endmodule

// ==== tb/mapper_assertions.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// bound into sys_mapper, every check is off while rst is high
// ------------------------------------------------------------
module mapper_assertions
    import mapper_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input cpu_bus_t cpu,
    input region_t  active,
    input logic     cpu_dtackn,
    input logic     mem_req,
    input logic     mem_ack,
    input mem_cmd_t mem_cmd
);

    // phase 3 may only follow phase 2
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (rst) mem_req && !mem_ack |=> mem_req
    ) else $error("mem_req dropped before mem_ack was seen");

    cmd_stable: assert property (
        @(posedge clk) disable iff (rst) mem_req && $past(mem_req) |-> mem_cmd == $past(mem_cmd)
    ) else $error("mem_cmd changed while mem_req was high");

    region_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(active)
    ) else $error("active has more than one region selected");

    // a released strobe always clears dtack on the same edge
    dtack_released: assert property (
        @(posedge clk) disable iff (rst) $past(cpu.asn) |-> cpu_dtackn
    ) else $error("cpu_dtackn low after asn was sampled high");

endmodule

bind sys_mapper mapper_assertions i_assertions (
    .clk        (clk),
    .rst        (rst),
    .cpu        (cpu),
    .active     (active),
    .cpu_dtackn (cpu_dtackn),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_cmd    (mem_cmd)
);

// ==== tb/mapper_tb.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// directed tests for sys_mapper, inputs change 1 ns after clk rises
// memory responder acks after 1 to 8 random cycles
// cpu writes need a freshly reset bank, the first mcu write locks them
// ------------------------------------------------------------
module mapper_tb
    import mapper_pkg::*;
();

    logic     clk;
    logic     rst;
    cpu_bus_t cpu;
    logic     cpu_dtackn;
    logic     cpu_brn;
    data_t    mapper_dout;
    region_t  active;
    logic     none;
    logic     mcu_en;
    logic     mcu_wr;
    reg_idx_t mcu_addr;
    byte_t    mcu_wdata;
    byte_t    mcu_rdata;
    logic     mcu_snd_intn;
    logic     snd_wr;
    logic     snd_rd;
    byte_t    snd_din;
    byte_t    snd_dout;
    logic     snd_pbf;
    logic     mem_req;
    mem_cmd_t mem_cmd;
    logic     mem_ack;
    data_t    mem_rdata;

    int       error_count = 0;
    int       test_count  = 0;
    int       cycle_count = 0;
    int       cycle_limit = 5000;   // tests take well under half of this
    int       seed        = 7283;
    int       req_cycles  = 0;
    logic     brn_high_in_req = 1'b0;
    mem_cmd_t last_cmd;

    // region setup, overlapping on purpose (r1 over r0, r4 in r3, r5 in r2)
    byte_t       region_bases  [NUM_REGIONS] = '{8'h10, 8'h10, 8'h40, 8'hE0,
                                                 8'hF2, 8'h41, 8'h60, 8'h88};
    size_code_t  region_sizes  [NUM_REGIONS] = '{2'd0, 2'd2, 2'd1, 2'd3, 2'd0, 2'd0, 2'd2, 2'd1};
    delay_code_t region_delays [NUM_REGIONS] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd3, 2'd0};
    addr_t       probe_addrs   [9] = '{23'h080000, 23'h0A1234, 23'h200010, 23'h208000,
                                       23'h790000, 23'h310000, 23'h441000, 23'h000100,
                                       23'h5A0000};
    addr_t       dtack_addrs   [4] = '{23'h080000, 23'h090000, 23'h200000, 23'h700000};

    tb_clock i_clock (.clk(clk));

    sys_mapper i_dut (.*);

    function automatic region_t expected_select(input addr_t a);
        int      n;
        region_t sel;
        sel = '0;
        for (int r = NUM_REGIONS - 1; r >= 0; r--) begin  // lowest match written last
            case (region_sizes[r])
                2'd0:    n = 8;
                2'd1:    n = 7;
                2'd2:    n = 5;
                default: n = 3;
            endcase
            if ((a >> (23 - n)) == ({15'd0, region_bases[r]} >> (8 - n)))
                sel = 8'b1 << r;
        end
        return sel;
    endfunction

    // word the responder returns for a read address
    function automatic data_t memory_word(input addr_t a);
        return a[15:0] ^ {a[22:16], 9'h0A5};
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic cpu_idle;
        cpu.asn = 1'b1;
        cpu.rnw = 1'b1;
        cpu.dsn = 2'b11;
        cpu.fc  = 3'b101;
    endtask

    task automatic apply_reset;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic cpu_write(input reg_idx_t idx, input byte_t data);
        cpu.asn  = 1'b0;
        cpu.rnw  = 1'b0;
        cpu.dsn  = 2'b00;
        cpu.fc   = 3'b101;
        cpu.addr = {18'h3F800, idx};   // unmapped while the bank is blank
        cpu.dout = {8'h00, data};
        next_cycle();
        next_cycle();
        cpu_idle();
        next_cycle();
    endtask

    task automatic mcu_write(input reg_idx_t idx, input byte_t data);
        mcu_en    = 1'b1;
        mcu_wr    = 1'b1;
        mcu_addr  = idx;
        mcu_wdata = data;
        next_cycle();
        mcu_en = 1'b0;
        mcu_wr = 1'b0;
    endtask

    task automatic mcu_read(input reg_idx_t idx, output byte_t data);
        mcu_en   = 1'b1;
        mcu_wr   = 1'b0;
        mcu_addr = idx;
        next_cycle();
        mcu_en = 1'b0;
        data   = mcu_rdata;
    endtask

    task automatic wait_transfer_done;
        byte_t st;
        next_cycle();                  // busy shows one cycle after the command
        st = 8'h40;
        while (st[6])
            mcu_read(MCU_RD_STATUS, st);
    endtask

    task automatic test_cpu_access;
        test_count++;
        cpu_write(REG_DATA_HI, 8'hA5);
        cpu_write(REG_DATA_LO, 8'h3C);
        if (mapper_dout !== 16'hA53C)
            report_error($sformatf("mapper_dout = %h, expected a53c", mapper_dout));
        mcu_write(5'd13, 8'h00);       // first mcu write takes the bank
        cpu_write(REG_DATA_HI, 8'h11);
        cpu_write(REG_DATA_LO, 8'h22);
        if (mapper_dout !== 16'hA53C)
            report_error($sformatf("cpu write after lock, mapper_dout = %h", mapper_dout));
    endtask

    task automatic test_region_decode;
        region_t expected;
        test_count++;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            mcu_write(reg_idx_t'(REG_REGION_BASE + 2 * r),
                      {4'b0000, region_delays[r], region_sizes[r]});
            mcu_write(reg_idx_t'(REG_REGION_BASE + 2 * r + 1), region_bases[r]);
        end
        for (int i = 0; i < 9; i++) begin
            cpu.fc   = 3'b101;
            cpu.addr = probe_addrs[i];
            expected = expected_select(probe_addrs[i]);
            @(negedge clk);
            if (active !== expected || none !== (expected == '0))
                report_error($sformatf("addr %h: active = %b none = %b, expected %b",
                                       probe_addrs[i], active, none, expected));
            next_cycle();
            cpu.fc = 3'b111;           // interrupt acknowledge
            @(negedge clk);
            if (active !== '0 || none !== 1'b0)
                report_error($sformatf("addr %h with fc 7: active = %b none = %b",
                                       probe_addrs[i], active, none));
            next_cycle();
        end
        cpu_idle();
    endtask

    task automatic check_dtack(input addr_t a, input delay_code_t code);
        logic expected;
        cpu.asn  = 1'b0;
        cpu.rnw  = 1'b1;
        cpu.dsn  = 2'b00;
        cpu.addr = a;
        next_cycle();                  // strobe first sampled low here
        if (cpu_dtackn !== 1'b1)
            report_error($sformatf("code %0d: cpu_dtackn low on the strobe edge", code));
        for (int n = 1; n <= code + 1; n++) begin
            next_cycle();
            expected = (n == code + 1) ? 1'b0 : 1'b1;
            if (cpu_dtackn !== expected)
                report_error($sformatf("code %0d edge %0d: cpu_dtackn = %b, expected %b",
                                       code, n, cpu_dtackn, expected));
        end
        cpu_idle();
        next_cycle();
        if (cpu_dtackn !== 1'b1)
            report_error($sformatf("code %0d: cpu_dtackn still low after asn rose", code));
    endtask

    task automatic test_dtack;
        test_count++;
        for (int i = 0; i < 4; i++)
            check_dtack(dtack_addrs[i], region_delays[i]);
    endtask

    task automatic test_write_transfer;
        test_count++;
        mcu_write(REG_WRADDR, 8'h12);
        mcu_write(REG_WRADDR + 5'd1, 8'h34);
        mcu_write(REG_WRADDR + 5'd2, 8'h56);
        mcu_write(REG_DATA_HI, 8'hBE);
        mcu_write(REG_DATA_LO, 8'hEF);
        req_cycles      = 0;
        brn_high_in_req = 1'b0;
        mcu_write(REG_CMD, 8'h01);
        wait_transfer_done();
        if (req_cycles == 0)
            report_error("write transfer: no memory request was seen");
        if (last_cmd.rnw !== 1'b0 || last_cmd.addr !== 23'h123456 || last_cmd.wdata !== 16'hBEEF)
            report_error($sformatf("write transfer: mem_cmd = %h, expected 0123456beef",
                                   last_cmd));
        if (brn_high_in_req)
            report_error("write transfer: cpu_brn high while mem_req was high");
        if (cpu_brn !== 1'b1)
            report_error("write transfer: cpu_brn still low after busy cleared");
    endtask

    task automatic test_read_transfer;
        byte_t hi;
        byte_t lo;
        test_count++;
        mcu_write(REG_RDADDR, 8'h2A);
        mcu_write(REG_RDADDR + 5'd1, 8'hBC);
        mcu_write(REG_RDADDR + 5'd2, 8'hDE);
        req_cycles = 0;
        mcu_write(REG_CMD, 8'h02);
        wait_transfer_done();
        if (req_cycles == 0 || last_cmd.rnw !== 1'b1 || last_cmd.addr !== 23'h2ABCDE)
            report_error($sformatf("read transfer: mem_cmd = %h after %0d request cycles",
                                   last_cmd, req_cycles));
        mcu_read(REG_DATA_HI, hi);
        mcu_read(REG_DATA_LO, lo);
        if ({hi, lo} !== memory_word(23'h2ABCDE))
            report_error($sformatf("read transfer: data = %h, expected %h",
                                   {hi, lo}, memory_word(23'h2ABCDE)));
    endtask

    task automatic test_sound_latch;
        byte_t rd;
        test_count++;
        apply_reset();
        cpu_write(REG_SND, 8'h6D);
        if (snd_dout !== 8'h6D || snd_pbf !== 1'b1)
            report_error($sformatf("snd_dout = %h snd_pbf = %b, expected 6d 1", snd_dout, snd_pbf));
        snd_rd = 1'b1;
        next_cycle();
        snd_rd = 1'b0;
        if (snd_pbf !== 1'b0)
            report_error("snd_pbf still set after snd_rd");
        snd_din = 8'h93;
        snd_wr  = 1'b1;
        next_cycle();
        snd_wr = 1'b0;
        if (mcu_snd_intn !== 1'b0)
            report_error("mcu_snd_intn not asserted after snd_wr");
        mcu_read(MCU_RD_SND, rd);
        if (rd !== 8'h93)
            report_error($sformatf("sound latch read = %h, expected 93", rd));
        if (mcu_snd_intn !== 1'b1)
            report_error("mcu_snd_intn still low after the latch was read");
    endtask

    // memory responder
    initial begin
        int wait_cycles;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            next_cycle();
            if (mem_req) begin
                wait_cycles = 1 + ($unsigned($random(seed)) % 8);
                repeat (wait_cycles - 1)
                    next_cycle();
                mem_ack   = 1'b1;
                mem_rdata = memory_word(mem_cmd.addr);
                while (mem_req)
                    next_cycle();
                next_cycle();          // ack drops one cycle after req fell
                mem_ack = 1'b0;
            end
        end
    end

    // transfer monitor, sampled mid cycle
    always @(negedge clk) begin
        if (mem_req) begin
            req_cycles++;
            last_cmd = mem_cmd;
            if (cpu_brn)
                brn_high_in_req = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        cpu       = '0;
        cpu_idle();
        mcu_en    = 1'b0;
        mcu_wr    = 1'b0;
        mcu_addr  = '0;
        mcu_wdata = '0;
        snd_wr    = 1'b0;
        snd_rd    = 1'b0;
        snd_din   = '0;
        apply_reset();
        test_cpu_access();
        test_region_decode();
        test_dtack();
        test_write_transfer();
        test_read_transfer();
        test_sound_latch();
        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/10ps
// ------------------------------------------------------------
// free running testbench clock, 10 ns period, starts low
// ------------------------------------------------------------
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule
